// File: logic/decode_pkg.sv
//----------------------------------------
// Decode package
// Micro-op encoding, ISA subsets, packet
// bundles and opcode constants shared by
// the decode-and-issue subsystem
//----------------------------------------

package decode_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  tag_t;

  // Micro-ops, order defines bit positions in rv_op_vec
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
    OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA,
    OP_ADDI, OP_LUI,
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_ILLEGAL
  } rv_uop;

  localparam int num_uops  = 17;
  localparam int num_pipes = 3;

  typedef logic [num_uops-1:0] rv_op_vec;

  //----------------------------------------
  // ISA subsets
  //----------------------------------------

  // Register ops, ADDI and LUI in bits 11..0
  localparam rv_op_vec op_vec_alu = 17'b0_0000_1111_1111_1111;
  // MUL through MULHU in bits 15..12
  localparam rv_op_vec op_vec_mul = 17'b0_1111_0000_0000_0000;

  // Pipe 0 and 1 are ALUs, pipe 2 multiplies
  localparam rv_op_vec pipe_subsets [num_pipes] = '{op_vec_alu, op_vec_alu, op_vec_mul};

  function automatic logic in_subset(rv_op_vec subset, rv_uop uop);
    return subset[uop];
  endfunction

  // RV32 major opcodes and funct7 groups
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] f7_base    = 7'b0000000;
  localparam logic [6:0] f7_alt     = 7'b0100000;
  localparam logic [6:0] f7_muldiv  = 7'b0000001;

  typedef struct packed {
    word_t inst;
    word_t op_a;
    word_t op_b;
    tag_t  tag;
  } issue_pkt_t;

  typedef struct packed {
    word_t data;
    tag_t  tag;
  } result_pkt_t;

endpackage

// File: logic/stage_buffer.sv
//----------------------------------------
// Stage buffer
// Two-entry val/rdy queue, full rate,
// generic payload type
//----------------------------------------

module stage_buffer #(
  parameter type t_payload = logic [31:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_val,
  output logic     in_rdy,
  input  t_payload in_data,
  output logic     out_val,
  input  logic     out_rdy,
  output t_payload out_data
);

  t_payload   mem [2];
  logic [1:0] count;
  logic       wr_ptr;
  logic       rd_ptr;
  logic       enq;
  logic       deq;

  assign in_rdy   = (count != 2'd2);
  assign out_val  = (count != 2'd0);
  assign out_data = mem[rd_ptr];

  assign enq = in_val & in_rdy;
  assign deq = out_val & out_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      count  <= 2'd0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (enq) wr_ptr <= ~wr_ptr;
      if (deq) rd_ptr <= ~rd_ptr;
      count <= count + {1'b0, enq} - {1'b0, deq};
    end
  end

  always_ff @(posedge clk) begin
    if (enq) mem[wr_ptr] <= in_data;
  end

endmodule

// File: logic/inst_decoder.sv
//----------------------------------------
// Instruction decoder
// RV32IM word to micro-op and operands,
// unsupported encodings flagged illegal
//----------------------------------------

module inst_decoder import decode_pkg::*; (
  input  word_t inst,
  input  word_t op_a,
  input  word_t op_b,
  output rv_uop uop,
  output word_t src_a,
  output word_t src_b,
  output logic  illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign src_a   = op_a;
  assign illegal = (uop == OP_ILLEGAL);

  always_comb begin
    uop   = OP_ILLEGAL;
    src_b = op_b;
    case (opcode)
      opc_op: begin
        if (funct7 == f7_base) begin
          case (funct3)
            3'b000:  uop = OP_ADD;
            3'b001:  uop = OP_SLL;
            3'b010:  uop = OP_SLT;
            3'b011:  uop = OP_SLTU;
            3'b100:  uop = OP_XOR;
            3'b101:  uop = OP_SRL;
            3'b110:  uop = OP_OR;
            default: uop = OP_AND;
          endcase
        end else if (funct7 == f7_alt) begin
          if (funct3 == 3'b000) uop = OP_SUB;
          else if (funct3 == 3'b101) uop = OP_SRA;
        end else if (funct7 == f7_muldiv) begin
          // Upper funct3 half is DIV/REM, left illegal
          case (funct3)
            3'b000:  uop = OP_MUL;
            3'b001:  uop = OP_MULH;
            3'b010:  uop = OP_MULHSU;
            3'b011:  uop = OP_MULHU;
            default: uop = OP_ILLEGAL;
          endcase
        end
      end
      opc_op_imm: begin
        if (funct3 == 3'b000) begin
          uop   = OP_ADDI;
          src_b = {{20{inst[31]}}, inst[31:20]};
        end
      end
      opc_lui: begin
        uop   = OP_LUI;
        src_b = {inst[31:12], 12'b0};
      end
      default: uop = OP_ILLEGAL;
    endcase
  end

endmodule

// File: logic/inst_router.sv
//----------------------------------------
// Instruction router
// Steers a micro-op to the first ready
// pipe whose ISA subset contains it
//----------------------------------------

module inst_router_unit import decode_pkg::*; #(
  parameter rv_op_vec isa_subset = op_vec_alu
) (
  input  rv_uop uop,
  input  logic  uop_val,
  input  logic  already_found,
  input  logic  rdy,
  output logic  val,
  output logic  been_found
);

  logic val_uop;

  assign val_uop = in_subset(isa_subset, uop);

  assign val        = val_uop & uop_val & !already_found;
  // A ready supporting pipe claims the op for all later units
  assign been_found = (val_uop & rdy) | already_found;

endmodule

//----------------------------------------
// Router chain, pipe 0 has top priority
//----------------------------------------

module inst_router import decode_pkg::*; (
  input  rv_uop                uop,
  input  logic                 uop_val,
  input  logic [num_pipes-1:0] pipe_rdy,
  output logic [num_pipes-1:0] pipe_val,
  output logic                 xfer
);

  logic [num_pipes:0] found;

  assign found[0] = 1'b0;

  for (genvar i = 0; i < num_pipes; i++) begin : g_unit
    inst_router_unit #(
      .isa_subset (pipe_subsets[i])
    ) unit_i (
      .uop           (uop),
      .uop_val       (uop_val),
      .already_found (found[i]),
      .rdy           (pipe_rdy[i]),
      .val           (pipe_val[i]),
      .been_found    (found[i+1])
    );
  end

  // End of chain set means some supporting pipe was ready
  assign xfer = uop_val & found[num_pipes];

endmodule

// File: logic/alu_pipe.sv
//----------------------------------------
// ALU pipe
// Single-cycle integer ops into a
// one-entry result buffer
//----------------------------------------

module alu_pipe import decode_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  in_val,
  output logic  in_rdy,
  input  rv_uop uop,
  input  word_t src_a,
  input  word_t src_b,
  input  tag_t  tag,
  output logic  res_val,
  input  logic  res_rdy,
  output word_t res_data,
  output tag_t  res_tag
);

  word_t       result;
  logic        buf_in_rdy;
  result_pkt_t buf_out;

  always_comb begin
    case (uop)
      OP_ADD, OP_ADDI: result = src_a + src_b;
      OP_SUB:          result = src_a - src_b;
      OP_AND:          result = src_a & src_b;
      OP_OR:           result = src_a | src_b;
      OP_XOR:          result = src_a ^ src_b;
      OP_SLT:          result = {31'b0, $signed(src_a) < $signed(src_b)};
      OP_SLTU:         result = {31'b0, src_a < src_b};
      OP_SLL:          result = src_a << src_b[4:0];
      OP_SRL:          result = src_a >> src_b[4:0];
      OP_SRA:          result = $signed(src_a) >>> src_b[4:0];
      OP_LUI:          result = src_b;
      default:         result = '0;
    endcase
  end

  // Only one entry used, accept while empty or draining
  assign in_rdy = buf_in_rdy & (!res_val | res_rdy);

  stage_buffer #(
    .t_payload (result_pkt_t)
  ) res_buf (
    .clk      (clk),
    .rst      (rst),
    .in_val   (in_val & in_rdy),
    .in_rdy   (buf_in_rdy),
    .in_data  ('{data: result, tag: tag}),
    .out_val  (res_val),
    .out_rdy  (res_rdy),
    .out_data (buf_out)
  );

  assign res_data = buf_out.data;
  assign res_tag  = buf_out.tag;

endmodule

// File: logic/mul_pipe.sv
//----------------------------------------
// Multiply pipe
// MUL, MULH, MULHSU, MULHU over two
// stages, stalls as a whole on hold
//----------------------------------------

module mul_pipe import decode_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  in_val,
  output logic  in_rdy,
  input  rv_uop uop,
  input  word_t src_a,
  input  word_t src_b,
  input  tag_t  tag,
  output logic  res_val,
  input  logic  res_rdy,
  output word_t res_data,
  output tag_t  res_tag
);

  // Stage one registers
  logic        s1_val;
  logic [32:0] s1_a;
  logic [32:0] s1_b;
  logic        s1_hi;
  tag_t        s1_tag;

  logic        s2_rdy;
  logic        buf_in_rdy;
  logic [63:0] prod;
  word_t       result;
  result_pkt_t buf_out;

  // Output stage takes data only while empty or draining
  assign s2_rdy = buf_in_rdy & (!res_val | res_rdy);
  assign in_rdy = !s1_val | s2_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
    end else if (in_rdy) begin
      s1_val <= in_val;
    end
  end

  // Sign bit extension depends on which operands are signed
  always_ff @(posedge clk) begin
    if (in_val & in_rdy) begin
      s1_a   <= {(uop == OP_MULH || uop == OP_MULHSU) & src_a[31], src_a};
      s1_b   <= {(uop == OP_MULH) & src_b[31], src_b};
      s1_hi  <= (uop != OP_MUL);
      s1_tag <= tag;
    end
  end

  //----------------------------------------
  // Stage two, product and half select
  //----------------------------------------

  assign prod   = $signed(s1_a) * $signed(s1_b);
  assign result = s1_hi ? prod[63:32] : prod[31:0];

  stage_buffer #(
    .t_payload (result_pkt_t)
  ) res_buf (
    .clk      (clk),
    .rst      (rst),
    .in_val   (s1_val & s2_rdy),
    .in_rdy   (buf_in_rdy),
    .in_data  ('{data: result, tag: s1_tag}),
    .out_val  (res_val),
    .out_rdy  (res_rdy),
    .out_data (buf_out)
  );

  assign res_data = buf_out.data;
  assign res_tag  = buf_out.tag;

endmodule

// File: logic/result_arbiter.sv
//----------------------------------------
// Result arbiter
// Fixed-priority merge of pipe results,
// lowest pipe number wins
//----------------------------------------

module result_arbiter import decode_pkg::*; (
  input  logic [num_pipes-1:0] res_val,
  input  word_t                res_data [num_pipes],
  input  tag_t                 res_tag  [num_pipes],
  output logic [num_pipes-1:0] res_rdy,
  output logic                 out_val,
  input  logic                 out_rdy,
  output word_t                out_data,
  output tag_t                 out_tag
);

  logic [num_pipes-1:0] grant;

  // Scan from the top so the lowest valid pipe is left standing
  always_comb begin
    grant    = '0;
    out_data = '0;
    out_tag  = '0;
    for (int i = num_pipes - 1; i >= 0; i--) begin
      if (res_val[i]) begin
        grant    = '0;
        grant[i] = 1'b1;
        out_data = res_data[i];
        out_tag  = res_tag[i];
      end
    end
  end

  assign out_val = |res_val;
  assign res_rdy = grant & {num_pipes{out_rdy}};

endmodule

// File: logic/decode_issue_top.sv
//----------------------------------------
// Decode and issue top
// Buffer, decode, route, two ALU pipes,
// one multiply pipe, result merge
//----------------------------------------

module decode_issue_top import decode_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  in_val,
  output logic  in_rdy,
  input  word_t inst,
  input  word_t op_a,
  input  word_t op_b,
  input  tag_t  tag,
  output logic  out_val,
  input  logic  out_rdy,
  output word_t out_data,
  output tag_t  out_tag,
  output logic  illegal_val,
  output tag_t  illegal_tag
);

  issue_pkt_t           head;
  logic                 head_val;
  logic                 xfer;
  rv_uop                uop;
  word_t                src_a;
  word_t                src_b;
  logic                 illegal;
  logic [num_pipes-1:0] pipe_val;
  logic [num_pipes-1:0] pipe_rdy;
  logic [num_pipes-1:0] res_val;
  logic [num_pipes-1:0] res_rdy;
  word_t                res_data [num_pipes];
  tag_t                 res_tag  [num_pipes];

  stage_buffer #(
    .t_payload (issue_pkt_t)
  ) in_buf (
    .clk      (clk),
    .rst      (rst),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .in_data  ('{inst: inst, op_a: op_a, op_b: op_b, tag: tag}),
    .out_val  (head_val),
    .out_rdy  (xfer | illegal),
    .out_data (head)
  );

  inst_decoder decoder (
    .inst    (head.inst),
    .op_a    (head.op_a),
    .op_b    (head.op_b),
    .uop     (uop),
    .src_a   (src_a),
    .src_b   (src_b),
    .illegal (illegal)
  );

  // Illegal ops leave the buffer in the same cycle they are shown
  assign illegal_val = head_val & illegal;
  assign illegal_tag = head.tag;

  inst_router router (
    .uop      (uop),
    .uop_val  (head_val),
    .pipe_rdy (pipe_rdy),
    .pipe_val (pipe_val),
    .xfer     (xfer)
  );

  for (genvar g = 0; g < 2; g++) begin : g_alu
    alu_pipe alu_i (
      .clk      (clk),
      .rst      (rst),
      .in_val   (pipe_val[g]),
      .in_rdy   (pipe_rdy[g]),
      .uop      (uop),
      .src_a    (src_a),
      .src_b    (src_b),
      .tag      (head.tag),
      .res_val  (res_val[g]),
      .res_rdy  (res_rdy[g]),
      .res_data (res_data[g]),
      .res_tag  (res_tag[g])
    );
  end

  mul_pipe mul_i (
    .clk      (clk),
    .rst      (rst),
    .in_val   (pipe_val[2]),
    .in_rdy   (pipe_rdy[2]),
    .uop      (uop),
    .src_a    (src_a),
    .src_b    (src_b),
    .tag      (head.tag),
    .res_val  (res_val[2]),
    .res_rdy  (res_rdy[2]),
    .res_data (res_data[2]),
    .res_tag  (res_tag[2])
  );

  result_arbiter arbiter (
    .res_val  (res_val),
    .res_data (res_data),
    .res_tag  (res_tag),
    .res_rdy  (res_rdy),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_data (out_data),
    .out_tag  (out_tag)
  );

endmodule

// File: tb/decode_issue_tb.sv
//----------------------------------------
// Decode and issue testbench
// Directed tests with a tag-indexed
// scoreboard and an RV32IM reference model
//----------------------------------------

module decode_issue_tb import decode_pkg::*; ();

  // Run limit is five times the expected test length
  localparam int test_cycles = 400;
  localparam int cycle_limit = 5 * test_cycles;

  logic  clk;
  logic  rst;
  logic  in_val;
  logic  in_rdy;
  word_t inst;
  word_t op_a;
  word_t op_b;
  tag_t  tag;
  logic  out_val;
  logic  out_rdy;
  word_t out_data;
  tag_t  out_tag;
  logic  illegal_val;
  tag_t  illegal_tag;

  word_t       exp_data [16];
  logic [15:0] pending;
  tag_t        ill_q [$];
  string       test_name;
  word_t       rng_state = 32'd2409;
  int          cycle_count = 0;

  decode_issue_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .in_val      (in_val),
    .in_rdy      (in_rdy),
    .inst        (inst),
    .op_a        (op_a),
    .op_b        (op_b),
    .tag         (tag),
    .out_val     (out_val),
    .out_rdy     (out_rdy),
    .out_data    (out_data),
    .out_tag     (out_tag),
    .illegal_val (illegal_val),
    .illegal_tag (illegal_tag)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  //----------------------------------------
  // Failure reporting and compare tasks
  //----------------------------------------

  task automatic abort_run(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_tag(string name, tag_t expected, tag_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s: expected tag %0d, actual tag %0d",
                          name, expected, actual));
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("error %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  //----------------------------------------
  // Stimulus helpers and reference model
  //----------------------------------------

  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // RV32IM encodings with arbitrary register fields
  function automatic word_t encode(rv_uop op, word_t b);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = 7'b0000000;
    f3 = 3'b000;
    case (op)
      OP_ADDI:   return {b[11:0], 5'd1, 3'b000, 5'd2, 7'b0010011};
      OP_LUI:    return {b[31:12], 5'd3, 7'b0110111};
      OP_SUB:    f7 = 7'b0100000;
      OP_SLL:    f3 = 3'b001;
      OP_SLT:    f3 = 3'b010;
      OP_SLTU:   f3 = 3'b011;
      OP_XOR:    f3 = 3'b100;
      OP_SRL:    f3 = 3'b101;
      OP_SRA: begin
        f7 = 7'b0100000;
        f3 = 3'b101;
      end
      OP_OR:     f3 = 3'b110;
      OP_AND:    f3 = 3'b111;
      OP_MUL:    f7 = 7'b0000001;
      OP_MULH: begin
        f7 = 7'b0000001;
        f3 = 3'b001;
      end
      OP_MULHSU: begin
        f7 = 7'b0000001;
        f3 = 3'b010;
      end
      OP_MULHU: begin
        f7 = 7'b0000001;
        f3 = 3'b011;
      end
      default:   f7 = 7'b0000000;
    endcase
    return {f7, 5'd5, 5'd4, f3, 5'd6, 7'b0110011};
  endfunction

  function automatic word_t ref_value(rv_uop op, word_t a, word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    ea = {{32{a[31]}}, a};
    eb = {{32{b[31]}}, b};
    case (op)
      OP_ADD:    return a + b;
      OP_SUB:    return a - b;
      OP_AND:    return a & b;
      OP_OR:     return a | b;
      OP_XOR:    return a ^ b;
      OP_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLTU:   return (a < b) ? 32'd1 : 32'd0;
      OP_SLL:    return a << b[4:0];
      OP_SRL:    return a >> b[4:0];
      OP_SRA:    return $signed(a) >>> b[4:0];
      OP_ADDI:   return a + {{20{b[11]}}, b[11:0]};
      OP_LUI:    return {b[31:12], 12'h000};
      OP_MUL:    prod = ea * eb;
      OP_MULH:   prod = ea * eb;
      OP_MULHSU: prod = ea * {32'h0, b};
      OP_MULHU:  prod = {32'h0, a} * {32'h0, b};
      default:   return 32'h0;
    endcase
    // Low half of the 64-bit product for MUL, high half otherwise
    return (op == OP_MUL) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic present_op(rv_uop op, word_t a, word_t b, tag_t t);
    exp_data[t] = ref_value(op, a, b);
    pending[t]  = 1'b1;
    in_val <= 1'b1;
    inst   <= encode(op, b);
    op_a   <= a;
    op_b   <= b;
    tag    <= t;
  endtask

  // Holds the current packet until a rising edge sees in_rdy high
  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_rdy;
      @(posedge clk);
    end
  endtask

  task automatic issue_op(rv_uop op, word_t a, word_t b, tag_t t);
    present_op(op, a, b, t);
    wait_accept();
  endtask

  task automatic issue_illegal(word_t word, tag_t t);
    ill_q.push_back(t);
    in_val <= 1'b1;
    inst   <= word;
    op_a   <= next_rand();
    op_b   <= next_rand();
    tag    <= t;
    wait_accept();
  endtask

  task automatic wait_drain();
    in_val <= 1'b0;
    while (pending != 16'h0 || ill_q.size() != 0) @(posedge clk);
  endtask

  //----------------------------------------
  // Result and illegal port monitor
  //----------------------------------------

  always @(negedge clk) begin
    if (!rst) begin
      if (out_val && out_rdy) begin
        if (!pending[out_tag]) begin
          abort_run($sformatf("result with tag %0d was not expected", out_tag));
        end
        check_word(test_name, exp_data[out_tag], out_data);
        pending[out_tag] = 1'b0;
      end
      if (illegal_val) begin
        if (ill_q.size() == 0) begin
          abort_run("illegal report with no illegal instruction outstanding");
        end
        check_tag(test_name, ill_q[0], illegal_tag);
        void'(ill_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      abort_run($sformatf("timeout: run went past %0d cycles", cycle_limit));
    end
  end

  //----------------------------------------
  // Tests
  //----------------------------------------

  task automatic test_reset_state();
    test_name = "reset_state";
    @(negedge clk);
    check_bit("reset_state out_val", 1'b0, out_val);
    check_bit("reset_state illegal_val", 1'b0, illegal_val);
    check_bit("reset_state in_rdy", 1'b1, in_rdy);
    @(posedge clk);
  endtask

  task automatic test_alu_ops();
    test_name = "alu_ops";
    for (int i = 0; i < 12; i++) begin
      issue_op(rv_uop'(5'(i)), next_rand(), next_rand(), 4'(i));
    end
    wait_drain();
  endtask

  task automatic test_mul_ops();
    word_t corner [4];
    test_name = "mul_ops";
    corner = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h0000_0003};
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        issue_op(rv_uop'(5'(12 + i)), corner[j], corner[(i + j + 1) % 4], 4'(i * 4 + j));
      end
    end
    wait_drain();
  endtask

  task automatic test_mixed_stream();
    logic [4:0] sel;
    test_name = "mixed_stream";
    for (int k = 0; k < 12; k++) begin
      if (k % 3 == 2) sel = 5'(12 + next_rand() % 4);
      else sel = 5'(next_rand() % 12);
      issue_op(rv_uop'(sel), next_rand(), next_rand(), 4'(k));
    end
    wait_drain();
  endtask

  task automatic test_illegal();
    test_name = "illegal";
    issue_op(OP_ADD, next_rand(), next_rand(), 4'd0);
    // Load, branch, divide and remainder encodings
    issue_illegal({12'h010, 5'd1, 3'b010, 5'd2, 7'b0000011}, 4'd1);
    issue_op(OP_MUL, next_rand(), next_rand(), 4'd2);
    issue_illegal({7'b0, 5'd2, 5'd1, 3'b000, 5'd8, 7'b1100011}, 4'd3);
    issue_illegal({7'b0000001, 5'd2, 5'd1, 3'b100, 5'd3, 7'b0110011}, 4'd4);
    issue_op(OP_SUB, next_rand(), next_rand(), 4'd5);
    issue_illegal({7'b0000001, 5'd2, 5'd1, 3'b111, 5'd3, 7'b0110011}, 4'd6);
    issue_op(OP_ADDI, next_rand(), next_rand(), 4'd7);
    wait_drain();
  endtask

  task automatic test_back_pressure();
    logic stalled;
    test_name = "back_pressure";
    stalled = 1'b0;
    out_rdy <= 1'b0;
    for (int i = 0; i < 8 && !stalled; i++) begin
      present_op(rv_uop'(5'(next_rand() % 12)), next_rand(), next_rand(), 4'(i));
      @(negedge clk);
      if (!in_rdy) stalled = 1'b1;
      else @(posedge clk);
    end
    if (!stalled) begin
      abort_run("in_rdy never fell while out_rdy was held low");
    end
    check_bit("back_pressure out_val", 1'b1, out_val);
    @(posedge clk);
    out_rdy <= 1'b1;
    // Stalled packet still has to go in
    wait_accept();
    wait_drain();
  endtask

  initial begin
    rst     = 1'b1;
    in_val  = 1'b0;
    inst    = '0;
    op_a    = '0;
    op_b    = '0;
    tag     = '0;
    out_rdy = 1'b1;
    pending = '0;
    test_name = "reset";
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_alu_ops();
    test_mul_ops();
    test_mixed_stream();
    test_illegal();
    test_back_pressure();
    repeat (4) @(posedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: sim.f
logic/decode_pkg.sv
logic/stage_buffer.sv
logic/inst_decoder.sv
logic/inst_router.sv
logic/alu_pipe.sv
logic/mul_pipe.sv
logic/result_arbiter.sv
logic/decode_issue_top.sv
tb/decode_issue_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode-and-issue testbench with Verilator.
# Exit status is nonzero when the build fails or the testbench stops with $fatal.
cd "$(dirname "$0")" &&
verilator --binary --top-module decode_issue_tb -f sim.f -o decode_issue_sim &&
./obj_dir/decode_issue_sim || exit 1
